// ==== all.f ====
source/fpuPkg.sv
source/fpDecoder.sv
source/fpRegFile.sv
source/fpSignCmp.sv
source/fpClassify.sv
source/fpuSubsys.sv
sim/fpuTb.sv

// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = fpuTb
FILELIST = all.f

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -F "All tests passed!"

clean:
	rm -rf obj_dir

// ==== sim/fpuTb.sv ====
`timescale 1ns/1ps

module fpuTb import fpuPkg::*; ();

  localparam int doneTimeout = 20;  // cycles allowed for the retire strobe

  logic                clk = 1'b0;
  logic                rstN;
  logic                instrValid;
  logic [31:0]         instr;
  logic [xlen-1:0]     intSrc;
  logic [2:0]          frmCsr;
  logic [1:0]          fpuStatus;
  logic                done, illegal, intWrite, fpWrite;
  logic [xlen-1:0]     intResult;
  logic [regAddrW-1:0] fpWriteAddr;
  logic [flen-1:0]     fpWriteData;
  logic                extIssue, extDivStart;
  resultSelE           extResultSel;
  logic [opCtrlW-1:0]  extOpCtrl;
  frmE                 extFrm;

  logic [flen-1:0] modelRegs [32];  // shadow copy of the fp registers
  logic [31:0]     lcgState = 32'd95;
  int              errorCount = 0;

  fpuSubsys dut0 (
    .clk          (clk),
    .rstN         (rstN),
    .instrValid   (instrValid),
    .instr        (instr),
    .intSrc       (intSrc),
    .frmCsr       (frmCsr),
    .fpuStatus    (fpuStatus),
    .done         (done),
    .illegal      (illegal),
    .intWrite     (intWrite),
    .intResult    (intResult),
    .fpWrite      (fpWrite),
    .fpWriteAddr  (fpWriteAddr),
    .fpWriteData  (fpWriteData),
    .extIssue     (extIssue),
    .extResultSel (extResultSel),
    .extOpCtrl    (extOpCtrl),
    .extDivStart  (extDivStart),
    .extFrm       (extFrm)
  );

  always #10 clk = ~clk;  // 20 ns period

  function automatic logic [31:0] nextRand();
    lcgState = lcgState * 32'd1664525 + 32'd1013904223;  // numerical recipes lcg
    return lcgState;
  endfunction

  function automatic int randBelow(input int n);
    return int'(nextRand() >> 8) % n;  // upper bits since the low ones cycle fast
  endfunction

  function automatic logic [4:0] randReg();
    logic [31:0] r;
    r = nextRand();
    return r[31:27];
  endfunction

  function automatic logic [1:0] legalStatus();
    return 2'(randBelow(3) + 1);  // any state but off
  endfunction

  function automatic logic [2:0] roundField();
    int n;
    n = randBelow(6);
    return (n == 5) ? 3'b111 : 3'(n);  // static modes or dynamic
  endfunction

  function automatic logic [31:0] encodeR(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd, input logic [6:0] opc);
    return {f7, rs2, rs1, f3, rd, opc};
  endfunction

  // mix of ordinary values and ieee corner cases
  function automatic logic [31:0] pickOperand();
    logic [31:0] r;
    r = nextRand();
    case (randBelow(9))
      0:       return 32'h00000000;
      1:       return 32'h80000000;
      2:       return 32'h7f800000;
      3:       return 32'hff800000;
      4:       return {r[31], 8'hff, 1'b1, r[21:0]};        // qnan
      5:       return {r[31], 8'hff, 1'b0, r[21:1], 1'b1};  // snan with a nonzero frac
      6:       return {r[31], 8'h00, r[22:1], 1'b1};        // subnormal
      default: return r;
    endcase
  endfunction

  // one value per class in fclass bit order
  function automatic logic [31:0] classAnchor(input int i);
    case (i)
      0:       return 32'hff800000;
      1:       return 32'hbf800000;
      2:       return 32'h80000001;
      3:       return 32'h80000000;
      4:       return 32'h00000000;
      5:       return 32'h00400000;
      6:       return 32'h3f800000;
      7:       return 32'h7f800000;
      8:       return 32'h7f800001;
      default: return 32'h7fc00000;
    endcase
  endfunction

  function automatic logic isNan(input logic [31:0] x);
    return (x[30:23] == 8'hff) && (x[22:0] != 23'd0);
  endfunction

  // maps floats onto unsigned order with -0 just below +0
  function automatic logic [31:0] orderKey(input logic [31:0] x);
    return x[31] ? ~x : {1'b1, x[30:0]};
  endfunction

  function automatic logic [31:0] modelMinMax(input logic [31:0] a, input logic [31:0] b,
                                              input logic isMin);
    if (isNan(a) && isNan(b)) return canonNan;
    if (isNan(a)) return b;
    if (isNan(b)) return a;
    if (isMin) return (orderKey(a) <= orderKey(b)) ? a : b;
    return (orderKey(a) >= orderKey(b)) ? a : b;
  endfunction

  // kind 0 eq, 1 lt, 2 le
  function automatic logic modelCompare(input logic [31:0] a, input logic [31:0] b,
                                        input int kind);
    logic eqv, ltv;
    eqv = (a == b) || ((a[30:0] == 31'd0) && (b[30:0] == 31'd0));  // +0 == -0
    ltv = (orderKey(a) < orderKey(b)) && !eqv;
    if (isNan(a) || isNan(b)) return 1'b0;  // unordered
    if (kind == 0) return eqv;
    if (kind == 1) return ltv;
    return eqv || ltv;
  endfunction

  function automatic logic [9:0] modelClass(input logic [31:0] x);
    logic [7:0]  e;
    logic [22:0] f;
    int          idx;
    e = x[30:23];
    f = x[22:0];
    if (e == 8'hff && f != 23'd0) idx = f[22] ? 9 : 8;
    else if (e == 8'hff) idx = x[31] ? 0 : 7;
    else if (e == 8'h00 && f == 23'd0) idx = x[31] ? 3 : 4;
    else if (e == 8'h00) idx = x[31] ? 2 : 5;
    else idx = x[31] ? 1 : 6;
    return 10'b1 << idx;
  endfunction

  // encodings outside the single-precision subset
  function automatic logic [31:0] illegalInstr(input int k);
    logic [4:0] a, b, d;
    a = randReg();
    b = randReg();
    d = randReg();
    case (k)
      0:       return encodeR(7'b0000001, b, a, 3'b000, d, opFp);      // fadd.d
      1:       return encodeR(7'b0010001, b, a, 3'b000, d, opFp);      // fsgnj.d
      2:       return encodeR(7'b0100000, 5'd1, a, 3'b000, d, opFp);   // fcvt.s.d
      3:       return encodeR(7'b0100001, 5'd0, a, 3'b000, d, opFp);   // fcvt.d.s
      4:       return encodeR(7'b1101000, 5'd2, a, 3'b000, d, opFp);   // fcvt.s.l
      5:       return encodeR(7'b1101000, 5'd3, a, 3'b000, d, opFp);   // fcvt.s.lu
      6:       return encodeR(7'b1100000, 5'd2, a, 3'b000, d, opFp);   // fcvt.l.s
      7:       return encodeR(7'b1100000, 5'd3, a, 3'b000, d, opFp);   // fcvt.lu.s
      8:       return encodeR(7'(nextRand()), b, a, 3'b011, d, opLoadFp);   // fld
      9:       return encodeR(7'(nextRand()), b, a, 3'b011, d, opStoreFp);  // fsd
      10:      return encodeR({b, 2'b01}, b, a, 3'b000, d, opMadd);    // fmadd.d
      11:      return encodeR(7'b0010000, b, a, 3'b011, d, opFp);      // bad sgnj funct3
      12:      return encodeR(7'b0010100, b, a, 3'b010, d, opFp);      // bad min/max funct3
      13:      return encodeR(7'b1010000, b, a, 3'b011, d, opFp);      // bad compare funct3
      14:      return encodeR(7'b1110000, 5'd0, a, 3'b010, d, opFp);   // bad fclass funct3
      15:      return encodeR(7'b1110001, 5'd0, a, 3'b000, d, opFp);   // fmv.x.d
      default: return encodeR(7'b0101100, 5'd1, a, 3'b000, d, opFp);   // fsqrt with rs2 != 0
    endcase
  endfunction

  task automatic stopWithFailure();
    errorCount++;
    $display("Test failures found");
    $fatal(1, "stopping at first error");
  endtask

  task automatic reportMismatch(input string msg);
    $display("mismatch at %0t ns: %s", $time, msg);
    stopWithFailure();
  endtask

  // one instruction, then wait for its retire strobe
  task automatic runInstr(input logic [31:0] ins, input logic [xlen-1:0] src,
                          input logic [2:0] csr, input logic [1:0] status);
    int waited;
    @(negedge clk);
    instr      = ins;
    intSrc     = src;
    frmCsr     = csr;
    fpuStatus  = status;
    instrValid = 1'b1;
    @(negedge clk);
    instrValid = 1'b0;
    waited     = 0;
    while (done !== 1'b1) begin
      if (waited >= doneTimeout) begin
        $display("timeout: no done within %0d cycles for instruction %08h", doneTimeout, ins);
        stopWithFailure();
      end
      @(negedge clk);
      waited++;
    end
  endtask

  task automatic expectStrobes(input logic ill, input logic fpw, input logic intw,
                               input logic iss, input logic div);
    if ({illegal, fpWrite, intWrite, extIssue, extDivStart} !== {ill, fpw, intw, iss, div}) begin
      reportMismatch($sformatf("ill/fpw/intw/iss/div %b%b%b%b%b, expected %b%b%b%b%b",
                               illegal, fpWrite, intWrite, extIssue, extDivStart,
                               ill, fpw, intw, iss, div));
    end
  endtask

  task automatic checkFpWrite(input logic [regAddrW-1:0] addr, input logic [flen-1:0] data);
    expectStrobes(1'b0, 1'b1, 1'b0, 1'b0, 1'b0);
    if (fpWriteAddr !== addr)
      reportMismatch($sformatf("fpWriteAddr %0d, expected %0d", fpWriteAddr, addr));
    if (fpWriteData !== data)
      reportMismatch($sformatf("fpWriteData %08h, expected %08h", fpWriteData, data));
  endtask

  task automatic checkIntResult(input logic [xlen-1:0] data);
    expectStrobes(1'b0, 1'b0, 1'b1, 1'b0, 1'b0);
    if (intResult !== data)
      reportMismatch($sformatf("intResult %08h, expected %08h", intResult, data));
  endtask

  task automatic checkIssue(input resultSelE sel, input logic [opCtrlW-1:0] oc,
                            input logic div, input frmE fr);
    expectStrobes(1'b0, 1'b0, 1'b0, 1'b1, div);
    if (extResultSel !== sel)
      reportMismatch($sformatf("extResultSel %s, expected %s", extResultSel.name(), sel.name()));
    if (extOpCtrl !== oc)
      reportMismatch($sformatf("extOpCtrl %b, expected %b", extOpCtrl, oc));
    if (extFrm !== fr)
      reportMismatch($sformatf("extFrm %b, expected %b", extFrm, fr));
  endtask

  task automatic checkIllegal();
    expectStrobes(1'b1, 1'b0, 1'b0, 1'b0, 1'b0);  // no write, no issue
  endtask

  task automatic loadRegister(input logic [4:0] rd, input logic [31:0] value);
    runInstr(encodeR(7'b1111000, 5'd0, randReg(), 3'b000, rd, opFp), value, 3'b000,
             legalStatus());  // fmv.w.x
    checkFpWrite(rd, value);
    modelRegs[rd] = value;
  endtask

  task automatic readRegister(input logic [4:0] rs);
    runInstr(encodeR(7'b1110000, 5'd0, rs, 3'b000, randReg(), opFp), nextRand(), 3'b000,
             legalStatus());  // fmv.x.w
    checkIntResult(modelRegs[rs]);
  endtask

  // table entry holds funct7 rs2 opcode resultSel opCtrl divStart
  task automatic issueExternal(input int k);
    logic [24:0]        entry;
    logic [6:0]         f7, opc;
    logic [4:0]         rs2f;
    logic [2:0]         f3, csr;
    logic [1:0]         selBits;
    logic [opCtrlW-1:0] oc;
    logic               div;
    case (k)
      0:       entry = {7'b0000000, 5'd0, opLoadFp,  resRead,   3'b000, 1'b0};  // flw
      1:       entry = {7'b0000000, 5'd0, opStoreFp, resRead,   3'b010, 1'b0};  // fsw
      2:       entry = {7'b0000000, 5'd0, opMadd,    resFma,    3'b000, 1'b0};
      3:       entry = {7'b0000000, 5'd0, opMsub,    resFma,    3'b001, 1'b0};
      4:       entry = {7'b0000000, 5'd0, opNmsub,   resFma,    3'b010, 1'b0};
      5:       entry = {7'b0000000, 5'd0, opNmadd,   resFma,    3'b011, 1'b0};
      6:       entry = {7'b0000000, 5'd0, opFp,      resFma,    3'b110, 1'b0};  // fadd
      7:       entry = {7'b0000100, 5'd0, opFp,      resFma,    3'b111, 1'b0};  // fsub
      8:       entry = {7'b0001000, 5'd0, opFp,      resFma,    3'b100, 1'b0};  // fmul
      9:       entry = {7'b0001100, 5'd0, opFp,      resDiv,    3'b000, 1'b1};  // fdiv
      10:      entry = {7'b0101100, 5'd0, opFp,      resDiv,    3'b001, 1'b1};  // fsqrt
      11:      entry = {7'b1101000, 5'd0, opFp,      resSimple, 3'b101, 1'b0};  // fcvt.s.w
      12:      entry = {7'b1101000, 5'd1, opFp,      resSimple, 3'b100, 1'b0};  // fcvt.s.wu
      13:      entry = {7'b1100000, 5'd0, opFp,      resSimple, 3'b001, 1'b0};  // fcvt.w.s
      default: entry = {7'b1100000, 5'd1, opFp,      resSimple, 3'b000, 1'b0};  // fcvt.wu.s
    endcase
    {f7, rs2f, opc, selBits, oc, div} = entry;
    if (k < 2) f7 = 7'(nextRand());                // offset bits of flw / fsw
    if (k >= 2 && k <= 5) f7 = {randReg(), 2'b00};  // rs3 with single fmt
    if (k <= 9) rs2f = randReg();                   // a real operand rather than a subtype
    f3  = (k < 2) ? 3'b010 : roundField();
    csr = 3'(randBelow(5));
    runInstr(encodeR(f7, rs2f, randReg(), f3, randReg(), opc), nextRand(), csr, legalStatus());
    checkIssue(resultSelE'(selBits), oc, div, frmE'((f3 == 3'b111) ? csr : f3));
  endtask

  initial begin
    logic [4:0]      ra, rb, rd;
    logic [2:0]      mode, f3;
    logic [31:0]     a, b, expFp;
    logic [xlen-1:0] expInt;
    logic [9:0]      expMask;
    int              op;
    rstN       = 1'b0;
    instrValid = 1'b0;
    instr      = '0;
    intSrc     = '0;
    frmCsr     = 3'b000;
    fpuStatus  = 2'b01;
    for (int r = 0; r < 32; r++) modelRegs[r] = '0;
    repeat (4) @(posedge clk);
    @(negedge clk);
    rstN = 1'b1;
    if ({done, illegal, intWrite, fpWrite, extIssue, extDivStart} !== 6'b0)
      reportMismatch("retire strobes not low after reset");

    // registers come up zero before the fill
    for (int r = 0; r < 32; r++) readRegister(5'(r));
    for (int r = 0; r < 32; r++) loadRegister(5'(r), pickOperand());

    // moves in both directions
    for (int i = 0; i < 40; i++) begin
      rd = randReg();
      loadRegister(rd, nextRand());
      readRegister(rd);
    end

    // sign injection
    for (int i = 0; i < 60; i++) begin
      ra = randReg();
      rb = randReg();
      rd = randReg();
      loadRegister(ra, pickOperand());
      loadRegister(rb, pickOperand());
      a    = modelRegs[ra];  // rb may alias ra
      b    = modelRegs[rb];
      mode = 3'(randBelow(3));
      if (mode == 3'b000) expFp = {b[31], a[30:0]};
      else if (mode == 3'b001) expFp = {~b[31], a[30:0]};
      else expFp = {a[31] ^ b[31], a[30:0]};
      runInstr(encodeR(7'b0010000, rb, ra, mode, rd, opFp), nextRand(), 3'b000, legalStatus());
      checkFpWrite(rd, expFp);
      modelRegs[rd] = expFp;
    end

    // min/max and compares
    for (int i = 0; i < 100; i++) begin
      ra = randReg();
      rb = randReg();
      rd = randReg();
      loadRegister(ra, pickOperand());
      if (randBelow(4) == 0) loadRegister(rb, modelRegs[ra] ^ 32'h80000000);  // sign pair
      else loadRegister(rb, pickOperand());
      a  = modelRegs[ra];
      b  = modelRegs[rb];
      op = randBelow(5);  // fmin fmax feq flt fle
      if (op < 2) begin
        expFp = modelMinMax(a, b, op == 0);
        runInstr(encodeR(7'b0010100, rb, ra, 3'(op), rd, opFp), nextRand(), 3'b000,
                 legalStatus());
        checkFpWrite(rd, expFp);
        modelRegs[rd] = expFp;
      end else begin
        f3     = (op == 2) ? 3'b010 : (op == 3) ? 3'b001 : 3'b000;
        expInt = {{(xlen-1){1'b0}}, modelCompare(a, b, op - 2)};
        runInstr(encodeR(7'b1010000, rb, ra, f3, rd, opFp), nextRand(), 3'b000, legalStatus());
        checkIntResult(expInt);
      end
    end

    // classify with anchors first so every class shows up
    for (int i = 0; i < 70; i++) begin
      ra = randReg();
      loadRegister(ra, (i < 10) ? classAnchor(i) : pickOperand());
      expMask = modelClass(modelRegs[ra]);
      runInstr(encodeR(7'b1110000, 5'd0, ra, 3'b001, randReg(), opFp), nextRand(), 3'b000,
               legalStatus());
      checkIntResult({{(xlen-10){1'b0}}, expMask});
    end

    // illegal encodings and then the fpu switched off
    for (int k = 0; k < 34; k++) begin
      runInstr(illegalInstr(k % 17), nextRand(), 3'(randBelow(5)), legalStatus());
      checkIllegal();
    end
    for (int i = 0; i < 10; i++) begin
      runInstr(encodeR(7'b1111000, 5'd0, randReg(), 3'b000, randReg(), opFp), nextRand(),
               3'b000, 2'b00);  // fmv.w.x
      checkIllegal();
      runInstr(encodeR(7'b0010000, randReg(), randReg(), 3'b000, randReg(), opFp), nextRand(),
               3'b000, 2'b00);  // fsgnj
      checkIllegal();
      runInstr(encodeR(7'b0000000, randReg(), randReg(), roundField(), randReg(), opFp),
               nextRand(), 3'b000, 2'b00);  // fadd
      checkIllegal();
    end
    for (int r = 0; r < 32; r++) readRegister(5'(r));  // nothing written

    // ops handed to the outside units
    for (int i = 0; i < 90; i++) issueExternal((i < 15) ? i : randBelow(15));
    for (int r = 0; r < 32; r++) readRegister(5'(r));

    if (errorCount == 0) begin
      $display("All tests passed!");
      $finish;
    end else begin
      stopWithFailure();
    end
  end

endmodule

// ==== source/fpuSubsys.sv ====
`timescale 1ns/1ps

module fpuSubsys import fpuPkg::*; (
  input  logic                clk,
  input  logic                rstN,
  input  logic                instrValid,
  input  logic [31:0]         instr,
  input  logic [xlen-1:0]     intSrc,       // rs1 from the integer file
  input  logic [2:0]          frmCsr,
  input  logic [1:0]          fpuStatus,
  output logic                done,
  output logic                illegal,
  output logic                intWrite,
  output logic [xlen-1:0]     intResult,
  output logic                fpWrite,
  output logic [regAddrW-1:0] fpWriteAddr,
  output logic [flen-1:0]     fpWriteData,
  output logic                extIssue,     // strobe to the outside units
  output resultSelE           extResultSel,
  output logic [opCtrlW-1:0]  extOpCtrl,
  output logic                extDivStart,
  output frmE                 extFrm
);

  logic                decIllegal;
  logic                fpRegWrite, writeInt, divStart;
  resultSelE           resultSel;
  resSelE              resSel;
  intResSelE           intResSel;
  logic [opCtrlW-1:0]  opCtrl;
  frmE                 frm;
  logic [flen-1:0]     srcA, srcB;
  logic [flen-1:0]     sgnRes, minMaxRes;
  logic                cmpBit;
  logic [9:0]          classMask;
  logic                simple;       // result produced here
  logic                wrEn;
  logic [flen-1:0]     fpResult;
  logic [xlen-1:0]     intRes;

  fpDecoder decoder0 (
    .opcode     (majorOpE'(instr[6:0])),
    .funct7     (instr[31:25]),
    .funct3     (instr[14:12]),
    .rs2        (instr[24:20]),
    .frmCsr     (frmCsr),
    .fpuStatus  (fpuStatus),
    .illegal    (decIllegal),
    .fpRegWrite (fpRegWrite),
    .writeInt   (writeInt),
    .divStart   (divStart),
    .resultSel  (resultSel),
    .resSel     (resSel),
    .intResSel  (intResSel),
    .opCtrl     (opCtrl),
    .frm        (frm)
  );

  // third port only feeds the external fma
  fpRegFile regFile0 (
    .clk     (clk),
    .rstN    (rstN),
    .rdAddr1 (instr[19:15]),
    .rdAddr2 (instr[24:20]),
    .rdAddr3 (instr[31:27]),
    .rdData1 (srcA),
    .rdData2 (srcB),
    .rdData3 (),
    .wrEn    (wrEn),
    .wrAddr  (instr[11:7]),
    .wrData  (fpResult)
  );

  fpSignCmp signCmp0 (
    .srcA      (srcA),
    .srcB      (srcB),
    .opCtrl    (opCtrl),
    .sgnRes    (sgnRes),
    .minMaxRes (minMaxRes),
    .cmpBit    (cmpBit)
  );

  fpClassify classify0 (
    .src       (srcA),
    .classMask (classMask)
  );

  // conversions decode as simple but are executed externally
  assign simple = (resultSel == resSimple) && (resSel != selCvt);
  assign wrEn   = instrValid && fpRegWrite && !decIllegal && simple;

  always_comb begin
    case (resSel)
      selSrcA: fpResult = intSrc;     // fmv.w.x
      selSgn:  fpResult = sgnRes;
      selCmp:  fpResult = minMaxRes;
      default: fpResult = '0;
    endcase
  end

  always_comb begin
    case (intResSel)
      intCmp:   intRes = {{(xlen-1){1'b0}}, cmpBit};
      intMove:  intRes = srcA;        // fmv.x.w raw bits
      intClass: intRes = {{(xlen-10){1'b0}}, classMask};
      default:  intRes = '0;
    endcase
  end

  // retire stage strobes
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      done        <= 1'b0;
      illegal     <= 1'b0;
      fpWrite     <= 1'b0;
      intWrite    <= 1'b0;
      extIssue    <= 1'b0;
      extDivStart <= 1'b0;
    end else begin
      done        <= instrValid;
      illegal     <= instrValid && decIllegal;
      fpWrite     <= wrEn;
      intWrite    <= instrValid && writeInt && simple;
      extIssue    <= instrValid && !decIllegal && !simple;
      extDivStart <= instrValid && divStart;  // fdiv / fsqrt
    end
  end

  // retire payload held between instructions
  always_ff @(posedge clk) begin
    if (instrValid) begin
      intResult    <= intRes;
      fpWriteAddr  <= instr[11:7];
      fpWriteData  <= fpResult;
      extResultSel <= resultSel;
      extOpCtrl    <= opCtrl;
      extFrm       <= frm;
    end
  end

  // each retired instruction leaves by exactly one path
  assert property (@(posedge clk) disable iff (!rstN)
    done |-> $onehot({illegal, fpWrite, intWrite, extIssue}))
    else $error("retire took zero or several exits");

endmodule

// ==== source/fpClassify.sv ====
`timescale 1ns/1ps

module fpClassify import fpuPkg::*; (
  input  logic [flen-1:0] src,
  output logic [9:0]      classMask
);

  logic       sign;
  logic [7:0] expo;
  logic       fracZero;
  logic       expMax, expZero;
  logic       isInf, isNan, isZero, isSub, isNorm;

  assign sign     = src[flen-1];
  assign expo     = src[30:23];
  assign fracZero = (src[22:0] == '0);
  assign expMax   = (expo == 8'hff);
  assign expZero  = (expo == 8'h00);

  assign isInf  = expMax && fracZero;
  assign isNan  = expMax && !fracZero;
  assign isZero = expZero && fracZero;
  assign isSub  = expZero && !fracZero;
  assign isNorm = !expMax && !expZero;

  // riscv fclass bit order
  assign classMask[0] = sign && isInf;
  assign classMask[1] = sign && isNorm;
  assign classMask[2] = sign && isSub;
  assign classMask[3] = sign && isZero;
  assign classMask[4] = !sign && isZero;
  assign classMask[5] = !sign && isSub;
  assign classMask[6] = !sign && isNorm;
  assign classMask[7] = !sign && isInf;
  assign classMask[8] = isNan && !src[22];  // quiet bit clear
  assign classMask[9] = isNan && src[22];

  always_comb begin
    assert final ($isunknown(src) || $onehot(classMask))
      else $error("class mask not one-hot");
  end

endmodule

// ==== source/fpSignCmp.sv ====
`timescale 1ns/1ps

module fpSignCmp import fpuPkg::*; (
  input  logic [flen-1:0]    srcA,
  input  logic [flen-1:0]    srcB,
  input  logic [opCtrlW-1:0] opCtrl,
  output logic [flen-1:0]    sgnRes,
  output logic [flen-1:0]    minMaxRes,
  output logic               cmpBit      // eq / lt / le
);

  logic signA, signB;
  logic nanA, nanB;
  logic bothZero;   // +0 and -0 in any mix
  logic ordLt;      // total order with -0 below +0
  logic eq, lt;
  logic cmpRaw;
  logic sgnBit;

  assign signA    = srcA[flen-1];
  assign signB    = srcB[flen-1];
  assign nanA     = (srcA[30:23] == 8'hff) && (srcA[22:0] != '0);
  assign nanB     = (srcB[30:23] == 8'hff) && (srcB[22:0] != '0);
  assign bothZero = (srcA[30:0] == '0) && (srcB[30:0] == '0);

  // sign-magnitude compare, magnitude order flips for negatives
  assign ordLt = (signA != signB) ? signA :
                 signA ? (srcB[30:0] < srcA[30:0]) : (srcA[30:0] < srcB[30:0]);

  assign eq = (srcA == srcB) || bothZero;  // ieee equality
  assign lt = ordLt && !bothZero;

  always_comb begin
    case (opCtrl[1:0])
      2'b10:   cmpRaw = eq;       // feq
      2'b01:   cmpRaw = lt;       // flt
      2'b11:   cmpRaw = lt || eq; // fle
      default: cmpRaw = 1'b0;
    endcase
  end

  assign cmpBit = cmpRaw && !nanA && !nanB;  // unordered gives 0

  // min when opCtrl[1] set, max otherwise
  always_comb begin
    if (nanA && nanB)  minMaxRes = canonNan;
    else if (nanA)     minMaxRes = srcB;
    else if (nanB)     minMaxRes = srcA;
    else if (opCtrl[1]) minMaxRes = ordLt ? srcA : srcB;
    else               minMaxRes = ordLt ? srcB : srcA;
  end

  always_comb begin
    case (opCtrl[1:0])
      2'b01:   sgnBit = ~signB;        // fsgnjn
      2'b10:   sgnBit = signA ^ signB; // fsgnjx
      default: sgnBit = signB;         // fsgnj
    endcase
  end

  assign sgnRes = {sgnBit, srcA[30:0]};  // magnitude always from A

  // ordered operands never produce a third value
  always_comb begin
    assert final ($isunknown({srcA, srcB, opCtrl}) || nanA || nanB ||
                  minMaxRes == srcA || minMaxRes == srcB)
      else $error("min/max returned neither operand");
  end

endmodule

// ==== source/fpRegFile.sv ====
`timescale 1ns/1ps

module fpRegFile import fpuPkg::*; (
  input  logic                clk,
  input  logic                rstN,
  input  logic [regAddrW-1:0] rdAddr1,
  input  logic [regAddrW-1:0] rdAddr2,
  input  logic [regAddrW-1:0] rdAddr3,  // fma addend
  output logic [flen-1:0]     rdData1,
  output logic [flen-1:0]     rdData2,
  output logic [flen-1:0]     rdData3,
  input  logic                wrEn,
  input  logic [regAddrW-1:0] wrAddr,
  input  logic [flen-1:0]     wrData
);

  logic [flen-1:0] regs [2**regAddrW];  // f0 is an ordinary register

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      for (int i = 0; i < 2**regAddrW; i++) begin
        regs[i] <= '0;
      end
    end else if (wrEn) begin
      regs[wrAddr] <= wrData;
    end
  end

  // async reads, no bypass
  // a write lands one edge before any dependent read
  assign rdData1 = regs[rdAddr1];
  assign rdData2 = regs[rdAddr2];
  assign rdData3 = regs[rdAddr3];

endmodule

// ==== source/fpDecoder.sv ====
`timescale 1ns/1ps

module fpDecoder import fpuPkg::*; (
  input  majorOpE             opcode,
  input  logic [6:0]          funct7,
  input  logic [2:0]          funct3,     // also the static rounding mode
  input  logic [regAddrW-1:0] rs2,        // conversion subtype
  input  logic [2:0]          frmCsr,
  input  logic [1:0]          fpuStatus,  // mstatus.fs
  output logic                illegal,
  output logic                fpRegWrite,
  output logic                writeInt,
  output logic                divStart,
  output resultSelE           resultSel,
  output resSelE              resSel,
  output intResSelE           intResSel,
  output logic [opCtrlW-1:0]  opCtrl,
  output frmE                 frm
);

  logic [ctrlW-1:0] ctrl;
  logic             fmtS;  // fmt field is single

  assign fmtS = (funct7[1:0] == 2'b00);

  always_comb begin
    ctrl = ctrlIllegal;  // unmatched encodings fall through to here
    if (fpuStatus != 2'b00) begin  // fpu off means everything is illegal
      case (opcode)
        opLoadFp:
          if (funct3 == 3'b010) ctrl = 13'b1_0_00_000_00_00_0_0;  // flw
        opStoreFp:
          if (funct3 == 3'b010) ctrl = 13'b0_0_00_010_00_00_0_0;  // fsw
        opMadd:  if (fmtS) ctrl = 13'b1_0_01_000_00_00_0_0;
        opMsub:  if (fmtS) ctrl = 13'b1_0_01_001_00_00_0_0;
        opNmsub: if (fmtS) ctrl = 13'b1_0_01_010_00_00_0_0;
        opNmadd: if (fmtS) ctrl = 13'b1_0_01_011_00_00_0_0;
        opFp: begin
          if (fmtS) begin  // double and quad stay illegal
            case (funct7[6:2])
              5'b00000: ctrl = 13'b1_0_01_110_00_00_0_0;  // fadd
              5'b00001: ctrl = 13'b1_0_01_111_00_00_0_0;  // fsub
              5'b00010: ctrl = 13'b1_0_01_100_00_00_0_0;  // fmul
              5'b00011: ctrl = 13'b1_0_10_000_00_00_1_0;  // fdiv
              5'b01011:
                if (rs2 == '0) ctrl = 13'b1_0_10_001_00_00_1_0;  // fsqrt
              5'b00100:
                case (funct3)
                  3'b000:  ctrl = 13'b1_0_11_000_01_00_0_0;  // fsgnj
                  3'b001:  ctrl = 13'b1_0_11_001_01_00_0_0;  // fsgnjn
                  3'b010:  ctrl = 13'b1_0_11_010_01_00_0_0;  // fsgnjx
                  default: ctrl = ctrlIllegal;
                endcase
              5'b00101:
                case (funct3)
                  3'b000:  ctrl = 13'b1_0_11_111_10_00_0_0;  // fmin
                  3'b001:  ctrl = 13'b1_0_11_101_10_00_0_0;  // fmax
                  default: ctrl = ctrlIllegal;
                endcase
              5'b10100:
                case (funct3)
                  3'b010:  ctrl = 13'b0_1_11_010_10_00_0_0;  // feq
                  3'b001:  ctrl = 13'b0_1_11_001_10_00_0_0;  // flt
                  3'b000:  ctrl = 13'b0_1_11_011_10_00_0_0;  // fle
                  default: ctrl = ctrlIllegal;
                endcase
              5'b11100:
                case (funct3)
                  3'b001:  ctrl = 13'b0_1_11_000_00_10_0_0;  // fclass
                  3'b000:  ctrl = 13'b0_1_11_100_00_01_0_0;  // fmv.x.w
                  default: ctrl = ctrlIllegal;
                endcase
              5'b11010:  // int -> fp, l/lu rejected
                case (rs2)
                  5'd0:    ctrl = 13'b1_0_11_101_11_00_0_0;  // fcvt.s.w
                  5'd1:    ctrl = 13'b1_0_11_100_11_00_0_0;  // fcvt.s.wu
                  default: ctrl = ctrlIllegal;
                endcase
              5'b11000:  // fp -> int
                case (rs2)
                  5'd0:    ctrl = 13'b0_1_11_001_11_11_0_0;  // fcvt.w.s
                  5'd1:    ctrl = 13'b0_1_11_000_11_11_0_0;  // fcvt.wu.s
                  default: ctrl = ctrlIllegal;
                endcase
              5'b11110:
                if (funct3 == 3'b000) ctrl = 13'b1_0_11_000_00_00_0_0;  // fmv.w.x
              default: ctrl = ctrlIllegal;  // includes fcvt.s.d
            endcase
          end
        end
        default: ctrl = ctrlIllegal;
      endcase
    end
  end

  // split the control word
  assign fpRegWrite = ctrl[12];
  assign writeInt   = ctrl[11];
  assign resultSel  = resultSelE'(ctrl[10:9]);
  assign opCtrl     = ctrl[8:6];
  assign resSel     = resSelE'(ctrl[5:4]);
  assign intResSel  = intResSelE'(ctrl[3:2]);
  assign divStart   = ctrl[1];
  assign illegal    = ctrl[0];

  // 111 in the instruction means dynamic
  assign frm = frmE'((funct3 == 3'b111) ? frmCsr : funct3);

  // an illegal decode must never trigger a side effect downstream
  always_comb begin
    assert final ($isunknown(ctrl) || !(illegal && (fpRegWrite || writeInt || divStart)))
      else $error("illegal decode with write or div start");
  end

endmodule

// ==== source/fpuPkg.sv ====
package fpuPkg;

  localparam int flen     = 32;  // single precision only
  localparam int xlen     = 32;  // rv32 integer side
  localparam int regAddrW = 5;
  localparam int opCtrlW  = 3;

  // decoder control word
  // fpRegWrite, writeInt, resultSel, opCtrl, resSel, intResSel, divStart, illegal
  localparam int ctrlW = 13;
  localparam logic [ctrlW-1:0] ctrlIllegal = 13'b0_0_00_000_00_00_0_1;

  localparam logic [flen-1:0] canonNan = 32'h7fc00000;

  // major opcodes seen by the fpu
  typedef enum logic [6:0] {
    opLoadFp  = 7'b0000111,  // flw
    opStoreFp = 7'b0100111,  // fsw
    opMadd    = 7'b1000011,
    opMsub    = 7'b1000111,
    opNmsub   = 7'b1001011,
    opNmadd   = 7'b1001111,
    opFp      = 7'b1010011   // everything else in op-fp
  } majorOpE;

  // where the fp result comes from
  typedef enum logic [1:0] {
    resRead   = 2'b00,  // load data
    resFma    = 2'b01,  // fma, add, sub, mul
    resDiv    = 2'b10,  // div and sqrt
    resSimple = 2'b11   // done inside this subsystem
  } resultSelE;

  // pick within the simple results
  typedef enum logic [1:0] {
    selSrcA = 2'b00,  // move from int side
    selSgn  = 2'b01,
    selCmp  = 2'b10,  // min/max and compares
    selCvt  = 2'b11   // int<->fp conversion, handled outside
  } resSelE;

  typedef enum logic [1:0] {
    intCmp   = 2'b00,  // eq/lt/le bit
    intMove  = 2'b01,  // raw fp bits
    intClass = 2'b10,
    intCvt   = 2'b11
  } intResSelE;

  typedef enum logic [2:0] {
    rne = 3'b000,  // nearest, ties to even
    rtz = 3'b001,
    rdn = 3'b010,  // toward -inf
    rup = 3'b011,  // toward +inf
    rmm = 3'b100,  // nearest, ties away from zero
    dyn = 3'b111   // use the csr mode
  } frmE;

endpackage
